/* exeStage.f */
+incdir+source
source/exePkg.sv
source/alu.sv
source/branchUnit.sv
source/dataMem.sv
source/mulUnit.sv
source/csrUnit.sv
source/exeStage.sv
bench/exeStageTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, pass only when the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module exeStageTb -f exeStage.f -o exeStageSim \
	&& ./obj_dir/exeStageSim | grep -q "Simulation PASSED" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

/* bench/exeStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exeStage_macros.svh"

module exeStageTb;

	localparam int MaxEntries = 128;

	typedef struct packed {
		exePkg::word_t a, b, bImm, jImm, uImm, sImm, pc, csrData, csrImm;
		exePkg::regAddr_t rd;
		exePkg::wbSel_t wbSel;
		exePkg::aluFn_t aluFn;
		exePkg::memOp_t memOp;
		exePkg::mulOp_t mulOp;
		exePkg::csrFn_t csrFn;
		exePkg::csrAddr_t csrAddr;
		exePkg::privMode_t mode;
		logic we, brNeq, brType, jump, jumpReg, csrWe;
		logic iMis, ecall, illegal, mret, sret, uret;
		logic mTimer, sTimer, ext, mTie, sTie, mEie, sEie;
	} entry_t;

	logic clk;
	logic nrst;
	entry_t drv; // fields wired straight to the DUT inputs
	entry_t cur;
	exePkg::privMode_t curMode;
	integer seed;
	int n;
	int cycles;
	int limit;

	entry_t tbl [MaxEntries];
	exePkg::word_t expWb [MaxEntries];
	exePkg::word_t expCsrWb [MaxEntries];
	exePkg::word_t expTarget [MaxEntries];
	logic expWe [MaxEntries];
	logic expCsrWe [MaxEntries];
	logic expTaken [MaxEntries];
	logic excAt [MaxEntries]; // exception seen at the edge that samples the entry
	logic sync [MaxEntries];
	logic isEcall [MaxEntries];
	int syncCode [MaxEntries];
	logic [7:0] shadow [1024]; // byte image of the data memory

	exePkg::word_t wbData, target, csrWb, pcExc, cause;
	exePkg::regAddr_t rd;
	exePkg::csrAddr_t csrWbAddr;
	logic we, bjTaken, csrWe, exception, mretOut, sretOut, uretOut;

	exeStage exeStage_i (
		.clk(clk), .nrst(nrst), .opA(drv.a), .opB(drv.b), .rdIn(drv.rd),
		.wbSelIn(drv.wbSel), .aluFnIn(drv.aluFn), .weIn(drv.we),
		.bImm(drv.bImm), .jImm(drv.jImm), .uImm(drv.uImm), .sImm(drv.sImm),
		.brNeq(drv.brNeq), .brType(drv.brType), .jump(drv.jump), .jumpReg(drv.jumpReg),
		.memOpIn(drv.memOp), .mulOpIn(drv.mulOp), .pcIn(drv.pc), .csrFnIn(drv.csrFn),
		.csrData(drv.csrData), .csrImm(drv.csrImm), .csrAddrIn(drv.csrAddr),
		.csrWeIn(drv.csrWe), .instrMisaligned(drv.iMis), .ecall(drv.ecall),
		.illegalInstr(drv.illegal), .mret(drv.mret), .sret(drv.sret), .uret(drv.uret),
		.mTimer(drv.mTimer), .sTimer(drv.sTimer), .extInterrupt(drv.ext),
		.mTie(drv.mTie), .sTie(drv.sTie), .mEie(drv.mEie), .sEie(drv.sEie),
		.currentMode(drv.mode), .wbData(wbData), .we(we), .rd(rd), .target(target),
		.bjTaken(bjTaken), .csrWb(csrWb), .csrWbAddr(csrWbAddr), .csrWe(csrWe),
		.pcExc(pcExc), .cause(cause), .exception(exception),
		.mretOut(mretOut), .sretOut(sretOut), .uretOut(uretOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: no end of test after %0d cycles", limit);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input exePkg::word_t got,
		input exePkg::word_t exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	function automatic exePkg::word_t rnd();
		return $random(seed);
	endfunction

	function automatic exePkg::word_t aluModel(exePkg::aluFn_t fn, exePkg::word_t a,
		exePkg::word_t b);
		case (fn)
			exePkg::aluAdd: return a + b;
			exePkg::aluSub: return a - b;
			exePkg::aluSll: return a << b[4:0];
			exePkg::aluSlt: return `XLEN'($signed(a) < $signed(b));
			exePkg::aluSltu: return `XLEN'(a < b);
			exePkg::aluXor: return a ^ b;
			exePkg::aluSrl: return a >> b[4:0];
			exePkg::aluSra: return $signed(a) >>> b[4:0];
			exePkg::aluOr: return a | b;
			default: return a & b;
		endcase
	endfunction

	// 64-bit product of the extended operands wraps like a signed multiply
	function automatic exePkg::word_t mulModel(exePkg::mulOp_t op, exePkg::word_t a,
		exePkg::word_t b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		ea = (op == exePkg::mulMulhu) ? {32'b0, a} : {{32{a[31]}}, a};
		eb = (op == exePkg::mulMul || op == exePkg::mulMulh) ? {{32{b[31]}}, b} : {32'b0, b};
		p = ea * eb;
		return (op == exePkg::mulMul) ? p[31:0] : p[63:32];
	endfunction

	function automatic exePkg::word_t csrModel(exePkg::csrFn_t fn, exePkg::word_t rs1,
		exePkg::word_t imm, exePkg::word_t old);
		exePkg::word_t src;
		src = fn[2] ? imm : rs1;
		case (fn[1:0])
			2'b01: return src;
			2'b10: return old | src;
			2'b11: return old & ~src;
			default: return old;
		endcase
	endfunction

	// interrupt flag above the cause code
	function automatic logic [5:0] interruptCode(entry_t e);
		logic lowMode;
		lowMode = (e.mode == exePkg::modeUser) || (e.mode == exePkg::modeSupervisor);
		if (e.mEie && e.ext)
			return {1'b1, 5'(`CAUSE_M_EXT)};
		else if (lowMode && e.sEie && e.ext)
			return {1'b1, 5'(`CAUSE_S_EXT)};
		else if (e.mTie && e.mTimer)
			return {1'b1, 5'(`CAUSE_M_TIMER)};
		else if (lowMode && e.sTie && e.sTimer)
			return {1'b1, 5'(`CAUSE_S_TIMER)};
		return 6'b0;
	endfunction

	task automatic startEntry();
		cur = '0;
		cur.mode = curMode;
		cur.pc = rnd() & 32'h0000_fffc;
		cur.rd = 5'(rnd()) | 5'd1;
	endtask

	task automatic push();
		int i;
		int size;
		exePkg::word_t sum;
		exePkg::word_t word;
		exePkg::word_t loadVal;
		logic [9:0] addr;
		logic isLoad, isStore, mis, denied;
		i = n;
		tbl[i] = cur;
		isLoad = cur.memOp inside {exePkg::memLb, exePkg::memLh, exePkg::memLw,
			exePkg::memLbu, exePkg::memLhu};
		isStore = cur.memOp inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
		size = 1;
		if (cur.memOp inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh})
			size = 2;
		if (cur.memOp inside {exePkg::memLw, exePkg::memSw})
			size = 4;
		sum = isStore ? cur.a + cur.sImm : cur.a + cur.b;
		addr = sum[9:0];
		mis = (isLoad || isStore) && ((size == 2 && sum[0]) || (size == 4 && sum[1:0] != 2'b00));
		denied = cur.csrWe && (cur.csrAddr[9:8] > 2'(cur.mode));
		// trap from two entries back if that one survived both edges
		excAt[i] = interruptCode(cur) != 6'b0;
		if (i >= 2 && !excAt[i-2] && !excAt[i-1] && sync[i-2])
			excAt[i] = 1'b1;
		sync[i] = cur.iMis | cur.ecall | cur.illegal | cur.mret | cur.sret | cur.uret |
			denied | mis;
		isEcall[i] = cur.ecall && !cur.iMis; // misaligned fetch ranks above ecall
		syncCode[i] = cur.iMis ? `CAUSE_I_MISALIGNED :
			(cur.illegal || denied) ? `CAUSE_ILLEGAL : mis ? `CAUSE_L_MISALIGNED : 0;
		expWe[i] = cur.we;
		expCsrWe[i] = cur.csrWe && !denied;
		expCsrWb[i] = csrModel(cur.csrFn, cur.a, cur.csrImm, cur.csrData);
		word = '0;
		for (int k = 0; k < size; k++)
			word[8*k +: 8] = shadow[addr + 10'(k)];
		case (cur.memOp)
			exePkg::memLb: loadVal = {{24{word[7]}}, word[7:0]};
			exePkg::memLh: loadVal = {{16{word[15]}}, word[15:0]};
			default: loadVal = word;
		endcase
		if (isStore && !mis && !excAt[i])
			for (int k = 0; k < size; k++)
				shadow[addr + 10'(k)] = cur.b[8*k +: 8];
		case (cur.wbSel)
			exePkg::wbLinkPc: expWb[i] = cur.pc + 32'd4;
			exePkg::wbMul: expWb[i] = mulModel(cur.mulOp, cur.a, cur.b);
			exePkg::wbUpperImm: expWb[i] = cur.uImm;
			exePkg::wbMem: expWb[i] = loadVal;
			exePkg::wbAuipc: expWb[i] = cur.pc + cur.uImm;
			exePkg::wbCsr: expWb[i] = cur.csrData;
			default: expWb[i] = aluModel(cur.aluFn, cur.a, cur.b);
		endcase
		expTaken[i] = (cur.brType && ((cur.a == cur.b) != cur.brNeq)) || cur.jump || cur.jumpReg;
		if (cur.jumpReg)
			expTarget[i] = (cur.a + cur.b) & ~32'd1;
		else
			expTarget[i] = cur.pc + (cur.jump ? cur.jImm : cur.bImm);
		n = n + 1;
	endtask

	task automatic addAlu(input exePkg::aluFn_t fn, input exePkg::word_t a,
		input exePkg::word_t b);
		startEntry();
		cur.aluFn = fn;
		cur.a = a;
		cur.b = b;
		cur.we = 1'b1;
		push();
	endtask

	task automatic addMem(input exePkg::memOp_t op, input exePkg::word_t offset,
		input exePkg::word_t data);
		startEntry();
		cur.memOp = op;
		cur.a = 32'h100;
		if (op inside {exePkg::memSb, exePkg::memSh, exePkg::memSw})
		begin
			cur.sImm = offset;
			cur.b = data;
		end
		else
		begin
			cur.b = offset; // I immediate on opB
			cur.wbSel = exePkg::wbMem;
			cur.we = 1'b1;
		end
		push();
	endtask

	task automatic addCsr(input exePkg::csrFn_t fn, input exePkg::csrAddr_t addr);
		startEntry();
		cur.csrFn = fn;
		cur.csrAddr = addr;
		cur.csrData = rnd();
		cur.csrImm = rnd() & 32'h1f;
		cur.a = rnd();
		cur.csrWe = 1'b1;
		cur.we = 1'b1;
		cur.wbSel = exePkg::wbCsr;
		push();
	endtask

	task automatic addIrq(input logic mt, input logic st, input logic ex, input logic [3:0] en);
		startEntry();
		cur.mTimer = mt;
		cur.sTimer = st;
		cur.ext = ex;
		{cur.mTie, cur.sTie, cur.mEie, cur.sEie} = en;
		push();
	endtask

	// trap flags in order iMis, ecall, illegal, sret, uret, then one ALU op behind it
	task automatic addTrap(input logic [4:0] flags);
		startEntry();
		{cur.iMis, cur.ecall, cur.illegal, cur.sret, cur.uret} = flags;
		push();
		addAlu(exePkg::aluAdd, rnd(), rnd());
	endtask

	task automatic buildTable();
		curMode = exePkg::modeMachine;
		for (int k = 0; k < 10; k++)
			addAlu(exePkg::aluFn_t'(k), rnd(), rnd());
		addAlu(exePkg::aluSlt, 32'hffff_fff0, 32'd3);
		for (int k = 0; k < 3; k++)
		begin
			startEntry(); // lui, auipc, jal, jalr
			cur.we = 1'b1;
			cur.uImm = rnd() & 32'hffff_f000;
			cur.wbSel = (k == 0) ? exePkg::wbUpperImm :
				(k == 1) ? exePkg::wbAuipc : exePkg::wbLinkPc;
			cur.jump = (k == 2);
			cur.jImm = rnd() & ~32'd1;
			push();
		end
		startEntry();
		cur.wbSel = exePkg::wbLinkPc;
		cur.we = 1'b1;
		cur.jumpReg = 1'b1;
		cur.a = rnd();
		cur.b = rnd();
		push();
		for (int k = 0; k < 8; k++)
		begin
			startEntry();
			cur.mulOp = exePkg::mulOp_t'(k % 4);
			cur.wbSel = exePkg::wbMul;
			cur.a = rnd();
			cur.b = rnd();
			cur.we = 1'b1;
			push();
		end
		addMem(exePkg::memSw, 32'h0, rnd());
		addMem(exePkg::memSw, 32'h20, rnd());
		addMem(exePkg::memSh, 32'h6, rnd());
		addMem(exePkg::memSb, 32'h9, rnd());
		addMem(exePkg::memLw, 32'h0, 0);
		addMem(exePkg::memLb, 32'h1, 0);
		addMem(exePkg::memLbu, 32'h3, 0);
		addMem(exePkg::memLh, 32'h2, 0);
		addMem(exePkg::memLhu, 32'h0, 0);
		addMem(exePkg::memLh, 32'h6, 0);
		addMem(exePkg::memLb, 32'h9, 0);
		addMem(exePkg::memLw, 32'h2, 0); // misaligned word load flushes the next two
		addAlu(exePkg::aluAdd, rnd(), rnd());
		addAlu(exePkg::aluOr, rnd(), rnd());
		for (int k = 0; k < 4; k++)
		begin
			startEntry();
			cur.brType = 1'b1;
			cur.brNeq = k[1];
			cur.a = rnd();
			cur.b = k[0] ? cur.a : rnd();
			cur.bImm = rnd() & 32'h0000_1ffe;
			push();
		end
		addCsr(3'b001, 12'h300);
		addCsr(3'b010, 12'h305);
		addCsr(3'b011, 12'h341);
		addCsr(3'b101, 12'h100);
		addCsr(3'b110, 12'h300);
		addCsr(3'b111, 12'h342);
		addIrq(1'b1, 1'b0, 1'b0, 4'b1000); // machine timer
		addAlu(exePkg::aluAdd, rnd(), rnd());
		addIrq(1'b0, 1'b0, 1'b1, 4'b0010); // machine external
		addIrq(1'b1, 1'b0, 1'b0, 4'b0000); // masked
		addIrq(1'b0, 1'b1, 1'b0, 4'b0100); // supervisor timer ignored in machine mode
		startEntry();
		cur.ecall = 1'b1;
		push();
		addAlu(exePkg::aluSub, rnd(), rnd());
		addMem(exePkg::memSw, 32'h20, rnd()); // flushed at the trap edge
		addAlu(exePkg::aluXor, rnd(), rnd());
		addMem(exePkg::memLw, 32'h20, 0);
		startEntry();
		cur.mret = 1'b1;
		push();
		addAlu(exePkg::aluAnd, rnd(), rnd());
		addAlu(exePkg::aluAdd, rnd(), rnd());
		curMode = exePkg::modeSupervisor;
		addAlu(exePkg::aluAdd, rnd(), rnd());
		addCsr(3'b001, 12'h300); // machine CSR from supervisor
		addAlu(exePkg::aluSll, rnd(), rnd());
		addAlu(exePkg::aluSrl, rnd(), rnd());
		startEntry();
		cur.ecall = 1'b1;
		push();
		addAlu(exePkg::aluSra, rnd(), rnd());
		addAlu(exePkg::aluAdd, rnd(), rnd());
		addIrq(1'b0, 1'b0, 1'b1, 4'b0001);
		addIrq(1'b0, 1'b1, 1'b0, 4'b0100);
		addAlu(exePkg::aluAdd, rnd(), rnd());
		addTrap(5'b10000); // misaligned fetch
		addAlu(exePkg::aluOr, rnd(), rnd());
		addTrap(5'b11000); // misaligned fetch ranks above ecall
		addAlu(exePkg::aluAnd, rnd(), rnd());
		addTrap(5'b01100); // ecall ranks above illegal
		addAlu(exePkg::aluXor, rnd(), rnd());
		addTrap(5'b00100);
		addIrq(1'b1, 1'b0, 1'b0, 4'b1000); // interrupt beats the illegal in stage 6
		addTrap(5'b00010); // sret
		addAlu(exePkg::aluSub, rnd(), rnd());
		addTrap(5'b00001); // uret
		addAlu(exePkg::aluAdd, rnd(), rnd());
		for (int k = 0; k < 2; k++)
		begin
			cur = '0;
			cur.mode = curMode;
			push();
		end
	endtask

	task automatic checkEntry(input int j, input int c);
		logic alive;
		logic [5:0] irq;
		exePkg::word_t expCause;
		alive = !excAt[j] && !excAt[j+1];
		irq = interruptCode(tbl[c]);
		if (irq[5])
			expCause = {1'b1, {(`XLEN-6){1'b0}}, irq[4:0]};
		else if (alive && sync[j])
			expCause = isEcall[j] ? `XLEN'(`CAUSE_U_CALL + int'(tbl[c].mode)) :
				`XLEN'(syncCode[j]);
		else
			expCause = '0;
		// a misaligned load's data is don't care
		if (!(alive && sync[j] && tbl[j].memOp != exePkg::memNone))
			checkValue("wbData", wbData, alive ? expWb[j] : '0);
		checkValue("we", `XLEN'(we), `XLEN'(alive && expWe[j]));
		checkValue("rd", `XLEN'(rd), alive ? `XLEN'(tbl[j].rd) : '0);
		checkValue("csrWe", `XLEN'(csrWe), `XLEN'(alive && expCsrWe[j]));
		checkValue("csrWb", csrWb, alive ? expCsrWb[j] : '0);
		checkValue("csrWbAddr", `XLEN'(csrWbAddr), alive ? `XLEN'(tbl[j].csrAddr) : '0);
		checkValue("pcExc", pcExc, excAt[j] ? '0 : tbl[j].pc);
		checkValue("mretOut", `XLEN'(mretOut), `XLEN'(alive && tbl[j].mret));
		checkValue("sretOut", `XLEN'(sretOut), `XLEN'(alive && tbl[j].sret));
		checkValue("uretOut", `XLEN'(uretOut), `XLEN'(alive && tbl[j].uret));
		checkValue("exception", `XLEN'(exception), `XLEN'(excAt[c]));
		checkValue("cause", cause, expCause);
	endtask

	initial
	begin
		seed = 32'h82b8;
		n = 0;
		cycles = 0;
		limit = 100000;
		nrst = 1'b0;
		drv = '0;
		drv.mode = exePkg::modeMachine;
		buildTable();
		limit = n * 4 + 40;
		repeat (8) @(negedge clk);
		nrst = 1'b1;
		#2;
		checkValue("we", `XLEN'(we), '0);
		checkValue("csrWe", `XLEN'(csrWe), '0);
		checkValue("exception", `XLEN'(exception), '0);
		for (int c = 0; c < n; c++)
		begin
			@(negedge clk);
			drv = tbl[c];
			#2;
			checkValue("bjTaken", `XLEN'(bjTaken), `XLEN'(expTaken[c]));
			checkValue("target", target, expTarget[c]);
			if (c >= 2)
				checkEntry(c - 2, c); // entry c-2 now sits in stage 6
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/exeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exeStage_macros.svh"

module exeStage (
	input wire clk,
	input wire nrst,
	input wire exePkg::word_t opA,
	input wire exePkg::word_t opB, // rs2, or the I immediate
	input wire exePkg::regAddr_t rdIn,
	input wire exePkg::wbSel_t wbSelIn,
	input wire exePkg::aluFn_t aluFnIn,
	input wire weIn,
	input wire exePkg::word_t bImm, jImm, uImm, sImm,
	input wire brNeq, brType, jump, jumpReg,
	input wire exePkg::memOp_t memOpIn,
	input wire exePkg::mulOp_t mulOpIn,
	input wire exePkg::word_t pcIn,
	input wire exePkg::csrFn_t csrFnIn,
	input wire exePkg::word_t csrData, csrImm,
	input wire exePkg::csrAddr_t csrAddrIn,
	input wire csrWeIn,
	input wire instrMisaligned, ecall, illegalInstr,
	input wire mret, sret, uret,
	input wire mTimer, sTimer, extInterrupt,
	input wire mTie, sTie, mEie, sEie,
	input wire exePkg::privMode_t currentMode,
	output exePkg::word_t wbData,
	output logic we,
	output exePkg::regAddr_t rd,
	output exePkg::word_t target,
	output logic bjTaken,
	output exePkg::word_t csrWb,
	output exePkg::csrAddr_t csrWbAddr,
	output logic csrWe,
	output exePkg::word_t pcExc,
	output exePkg::word_t cause,
	output logic exception,
	output logic mretOut, sretOut, uretOut
);

	exePkg::word_t opA5, opB5, uImm5, pc5, csrData5, csrImm5;
	exePkg::regAddr_t rd5;
	exePkg::wbSel_t wbSel5;
	exePkg::aluFn_t aluFn5;
	exePkg::mulOp_t mulOp5;
	exePkg::csrFn_t csrFn5;
	exePkg::csrAddr_t csrAddr5;
	logic we5, csrWe5, iMis5, ecall5, illegal5, mret5, sret5, uret5;

	exePkg::word_t aluRes5, mulRes5, csrNew5;
	logic denied5;

	exePkg::wbSel_t wbSel6;
	exePkg::word_t aluRes6, mulRes6, uImm6, auipc6, csrOld6, memOut6;
	logic iMis6, ecall6, illegal6, memMis6;

	logic mTimerOn, sTimerOn, mExtOn, sExtOn, interrupt;
	logic [`CAUSE_CODE_W-1:0] code;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			opA5 <= '0;
			opB5 <= '0;
			uImm5 <= '0;
			pc5 <= '0;
			rd5 <= '0;
			wbSel5 <= exePkg::wbAlu;
			aluFn5 <= exePkg::aluAdd;
			we5 <= 1'b0;
			mulOp5 <= exePkg::mulMul;
			csrFn5 <= '0;
			csrData5 <= '0;
			csrImm5 <= '0;
			csrAddr5 <= '0;
			csrWe5 <= 1'b0;
			iMis5 <= 1'b0;
			ecall5 <= 1'b0;
			illegal5 <= 1'b0;
			mret5 <= 1'b0;
			sret5 <= 1'b0;
			uret5 <= 1'b0;
		end
		else
		begin
			// a trap in stage 6 turns the incoming instruction into a bubble
			opA5 <= exception ? '0 : opA;
			opB5 <= exception ? '0 : opB;
			uImm5 <= exception ? '0 : uImm;
			pc5 <= exception ? '0 : pcIn;
			rd5 <= exception ? '0 : rdIn;
			wbSel5 <= exception ? exePkg::wbAlu : wbSelIn;
			aluFn5 <= exception ? exePkg::aluAdd : aluFnIn;
			we5 <= weIn & ~exception;
			mulOp5 <= exception ? exePkg::mulMul : mulOpIn;
			csrFn5 <= exception ? '0 : csrFnIn;
			csrData5 <= exception ? '0 : csrData;
			csrImm5 <= exception ? '0 : csrImm;
			csrAddr5 <= exception ? '0 : csrAddrIn;
			csrWe5 <= csrWeIn & ~exception;
			iMis5 <= instrMisaligned & ~exception;
			ecall5 <= ecall & ~exception;
			illegal5 <= illegalInstr & ~exception;
			mret5 <= mret & ~exception;
			sret5 <= sret & ~exception;
			uret5 <= uret & ~exception;
		end
	end

	alu aluInst (.fn(aluFn5), .a(opA5), .b(opB5), .result(aluRes5));

	// branch decision is made on the issue values, no stage-5 delay
	branchUnit branchInst (
		.pc(pcIn), .a(opA), .b(opB), .bImm(bImm), .jImm(jImm),
		.brType(brType), .brNeq(brNeq), .jump(jump), .jumpReg(jumpReg),
		.taken(bjTaken), .target(target)
	);

	dataMem memInst (
		.clk(clk), .nrst(nrst), .op(memOpIn),
		.base(opA), .storeData(opB), .sImm(sImm), .flush(exception),
		.loadData(memOut6), .misaligned(memMis6)
	);

	mulUnit mulInst (.op(mulOp5), .a(opA5), .b(opB5), .result(mulRes5));

	csrUnit csrInst (
		.fn(csrFn5), .rs1(opA5), .imm(csrImm5), .old(csrData5),
		.addr(csrAddr5), .mode(currentMode), .newValue(csrNew5), .denied(denied5)
	);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wbSel6 <= exePkg::wbAlu;
			rd <= '0;
			we <= 1'b0;
			aluRes6 <= '0;
			mulRes6 <= '0;
			uImm6 <= '0;
			auipc6 <= '0;
			csrOld6 <= '0;
			csrWb <= '0;
			csrWbAddr <= '0;
			csrWe <= 1'b0;
			pcExc <= '0;
			iMis6 <= 1'b0;
			ecall6 <= 1'b0;
			illegal6 <= 1'b0;
			mretOut <= 1'b0;
			sretOut <= 1'b0;
			uretOut <= 1'b0;
		end
		else
		begin
			wbSel6 <= exception ? exePkg::wbAlu : wbSel5;
			rd <= exception ? '0 : rd5;
			we <= we5 & ~exception;
			aluRes6 <= exception ? '0 : aluRes5;
			mulRes6 <= exception ? '0 : mulRes5;
			uImm6 <= exception ? '0 : uImm5;
			auipc6 <= exception ? '0 : uImm5 + pc5;
			csrOld6 <= exception ? '0 : csrData5; // old value goes to rd
			csrWb <= exception ? '0 : csrNew5;
			csrWbAddr <= exception ? '0 : csrAddr5;
			csrWe <= csrWe5 & ~denied5 & ~exception;
			pcExc <= pc5; // kept on flush, names the killed instruction
			iMis6 <= iMis5 & ~exception;
			ecall6 <= ecall5 & ~exception;
			illegal6 <= (illegal5 | (csrWe5 & denied5)) & ~exception;
			mretOut <= mret5 & ~exception;
			sretOut <= sret5 & ~exception;
			uretOut <= uret5 & ~exception;
		end
	end

	// supervisor interrupts are masked while in machine mode
	assign mTimerOn = mTie & mTimer;
	assign sTimerOn = (currentMode <= exePkg::modeSupervisor) & sTie & sTimer;
	assign mExtOn = mEie & extInterrupt;
	assign sExtOn = (currentMode <= exePkg::modeSupervisor) & sEie & extInterrupt;
	assign interrupt = mExtOn | sExtOn | mTimerOn | sTimerOn;

	assign exception = interrupt | iMis6 | ecall6 | illegal6 | memMis6 |
		mretOut | sretOut | uretOut;

	always_comb
	begin
		if (mExtOn)
			code = `CAUSE_CODE_W'(`CAUSE_M_EXT);
		else if (sExtOn)
			code = `CAUSE_CODE_W'(`CAUSE_S_EXT);
		else if (mTimerOn)
			code = `CAUSE_CODE_W'(`CAUSE_M_TIMER);
		else if (sTimerOn)
			code = `CAUSE_CODE_W'(`CAUSE_S_TIMER);
		else if (iMis6)
			code = `CAUSE_CODE_W'(`CAUSE_I_MISALIGNED);
		else if (ecall6)
			code = `CAUSE_CODE_W'(`CAUSE_U_CALL) + `CAUSE_CODE_W'(currentMode);
		else if (illegal6)
			code = `CAUSE_CODE_W'(`CAUSE_ILLEGAL);
		else if (memMis6)
			code = `CAUSE_CODE_W'(`CAUSE_L_MISALIGNED); // stores share the load code
		else
			code = '0; // xret only flushes
	end

	assign cause = {interrupt, {(`XLEN-1-`CAUSE_CODE_W){1'b0}}, code};

	always_comb
	begin
		case (wbSel6)
			exePkg::wbAlu:
				wbData = aluRes6;
			exePkg::wbLinkPc:
				wbData = pcExc + `XLEN'(4);
			exePkg::wbMul:
				wbData = mulRes6;
			exePkg::wbUpperImm:
				wbData = uImm6;
			exePkg::wbMem:
				wbData = memOut6;
			exePkg::wbAuipc:
				wbData = auipc6;
			exePkg::wbCsr:
				wbData = csrOld6;
			default:
				wbData = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/csrUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module csrUnit (
	input wire exePkg::csrFn_t fn,
	input wire exePkg::word_t rs1,
	input wire exePkg::word_t imm,
	input wire exePkg::word_t old,
	input wire exePkg::csrAddr_t addr,
	input wire exePkg::privMode_t mode,
	output exePkg::word_t newValue,
	output logic denied
);

	exePkg::word_t src;

	assign src = fn[2] ? imm : rs1; // csrrwi, csrrsi, csrrci

	always_comb
	begin
		case (fn[1:0])
			2'b01:
				newValue = src;
			2'b10:
				newValue = old | src;
			2'b11:
				newValue = old & ~src;
			default:
				newValue = old;
		endcase
	end

	// addr[9:8] holds the lowest privilege allowed to touch the CSR
	assign denied = addr[9:8] > mode;

endmodule

`default_nettype wire

/* source/mulUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exeStage_macros.svh"

module mulUnit (
	input wire exePkg::mulOp_t op,
	input wire exePkg::word_t a,
	input wire exePkg::word_t b,
	output exePkg::word_t result
);

	logic signA;
	logic signB;
	logic signed [`XLEN:0] aExt;
	logic signed [`XLEN:0] bExt;
	logic signed [2*`XLEN+1:0] product;

	// mulhu treats both as unsigned, mulhsu only b
	assign signA = (op != exePkg::mulMulhu);
	assign signB = (op == exePkg::mulMul) || (op == exePkg::mulMulh);

	assign aExt = {signA & a[`XLEN-1], a};
	assign bExt = {signB & b[`XLEN-1], b};
	assign product = aExt * bExt;

	// low word is the same for every signedness
	assign result = (op == exePkg::mulMul) ? product[`XLEN-1:0] :
		product[2*`XLEN-1:`XLEN];

endmodule

`default_nettype wire

/* source/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exeStage_macros.svh"

module dataMem (
	input wire clk,
	input wire nrst,
	input wire exePkg::memOp_t op,
	input wire exePkg::word_t base,
	input wire exePkg::word_t storeData, // store source, or I immediate for loads
	input wire exePkg::word_t sImm,
	input wire flush,
	output exePkg::word_t loadData,
	output logic misaligned
);

	localparam int IdxW = $clog2(`DMEM_WORDS);

	exePkg::word_t mem [`DMEM_WORDS];
	exePkg::word_t addr;
	exePkg::word_t wrData;
	exePkg::word_t shifted;
	exePkg::word_t aligned;
	exePkg::memOp_t opR;
	logic isStore;
	logic isHalf;
	logic isWord;
	logic addrBad;
	logic [3:0] byteEn;
	logic [1:0] offR;
	logic [IdxW-1:0] idxR;
	logic misR;

	assign isStore = op inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
	assign isHalf = op inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh};
	assign isWord = op inside {exePkg::memLw, exePkg::memSw};
	assign addr = base + (isStore ? sImm : storeData);
	assign addrBad = (isHalf & addr[0]) | (isWord & (addr[1:0] != 2'b00));

	always_comb
	begin
		case (op)
			exePkg::memSb:
				byteEn = 4'b0001 << addr[1:0];
			exePkg::memSh:
				byteEn = 4'b0011 << addr[1:0];
			exePkg::memSw:
				byteEn = 4'b1111;
			default:
				byteEn = 4'b0000;
		endcase
		if (addrBad || flush)
			byteEn = 4'b0000; // no partial write on a trap
	end

	// replicate the narrow data so every lane holds it
	assign wrData = (op == exePkg::memSb) ? {4{storeData[7:0]}} :
		(op == exePkg::memSh) ? {2{storeData[15:0]}} : storeData;

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
			if (byteEn[i])
				mem[addr[IdxW+1:2]][8*i +: 8] <= wrData[8*i +: 8];
	end

	assign shifted = mem[idxR] >> {offR, 3'b000};

	always_comb
	begin
		case (opR)
			exePkg::memLb:
				aligned = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
			exePkg::memLbu:
				aligned = {{(`XLEN-8){1'b0}}, shifted[7:0]};
			exePkg::memLh:
				aligned = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
			exePkg::memLhu:
				aligned = {{(`XLEN-16){1'b0}}, shifted[15:0]};
			exePkg::memLw:
				aligned = shifted;
			default:
				aligned = '0;
		endcase
	end

	// address stage with stage 5, data stage with stage 6
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			opR <= exePkg::memNone;
			offR <= '0;
			idxR <= '0;
			misR <= 1'b0;
			loadData <= '0;
			misaligned <= 1'b0;
		end
		else
		begin
			opR <= flush ? exePkg::memNone : op;
			offR <= addr[1:0];
			idxR <= addr[IdxW+1:2];
			misR <= addrBad & ~flush;
			loadData <= flush ? '0 : aligned;
			misaligned <= misR & ~flush;
		end
	end

endmodule

`default_nettype wire

/* source/branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exeStage_macros.svh"

module branchUnit (
	input wire exePkg::word_t pc,
	input wire exePkg::word_t a,
	input wire exePkg::word_t b,
	input wire exePkg::word_t bImm,
	input wire exePkg::word_t jImm,
	input wire brType,
	input wire brNeq,
	input wire jump,
	input wire jumpReg,
	output logic taken,
	output exePkg::word_t target
);

	logic brTaken;

	// beq, or bne when brNeq flips the compare
	assign brTaken = brType & ((a == b) ^ brNeq);
	assign taken = brTaken | jump | jumpReg;

	always_comb
	begin
		if (jumpReg)
			target = (a + b) & {{(`XLEN-1){1'b1}}, 1'b0}; // jalr drops bit 0
		else if (jump)
			target = pc + jImm;
		else
			target = pc + bImm;
	end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exeStage_macros.svh"

module alu (
	input wire exePkg::aluFn_t fn,
	input wire exePkg::word_t a,
	input wire exePkg::word_t b,
	output exePkg::word_t result
);

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = b[4:0]; // rv32 shifts ignore the upper bits
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb
	begin
		case (fn)
			exePkg::aluAdd:
				result = a + b;
			exePkg::aluSub:
				result = a - b;
			exePkg::aluSll:
				result = a << shamt;
			exePkg::aluSlt:
				result = {{(`XLEN-1){1'b0}}, lessSigned};
			exePkg::aluSltu:
				result = {{(`XLEN-1){1'b0}}, lessUnsigned};
			exePkg::aluXor:
				result = a ^ b;
			exePkg::aluSrl:
				result = a >> shamt;
			exePkg::aluSra:
				result = $signed(a) >>> shamt; // sign bit fills from the left
			exePkg::aluOr:
				result = a | b;
			exePkg::aluAnd:
				result = a & b;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/exePkg.sv */
`default_nettype none

`include "exeStage_macros.svh"

package exePkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [11:0] csrAddr_t;

	// funct3 of a CSR instruction, bit 2 picks the immediate source
	typedef logic [2:0] csrFn_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluFn_t;

	// writeback source for the register file
	typedef enum logic [2:0] {
		wbAlu,
		wbLinkPc,
		wbMul,
		wbUpperImm,
		wbMem,
		wbAuipc,
		wbCsr
	} wbSel_t;

	typedef enum logic [3:0] {
		memNone,
		memLb,
		memLh,
		memLw,
		memLbu,
		memLhu,
		memSb,
		memSh,
		memSw
	} memOp_t;

	typedef enum logic [2:0] {
		mulMul,
		mulMulh,
		mulMulhsu,
		mulMulhu
	} mulOp_t;

	typedef enum logic [1:0] {
		modeUser = 2'd0,
		modeSupervisor = 2'd1,
		modeMachine = 2'd3
	} privMode_t;

endpackage

`default_nettype wire

/* source/exeStage_macros.svh */
`ifndef EXESTAGE_MACROS_SVH
`define EXESTAGE_MACROS_SVH

`define XLEN 32
`define DMEM_WORDS 256

// exception code field, below the interrupt bit
`define CAUSE_CODE_W 5

// synchronous exceptions
`define CAUSE_I_MISALIGNED 0
`define CAUSE_ILLEGAL 2
`define CAUSE_L_MISALIGNED 4
`define CAUSE_U_CALL 8

// interrupts
`define CAUSE_S_TIMER 5
`define CAUSE_M_TIMER 7
`define CAUSE_S_EXT 9
`define CAUSE_M_EXT 11

`endif
